// File: src/perf_pkg.sv
// Shared types and constants for the cache and counter complex
// Bus is Wishbone classic with word addresses, data is XLEN wide
// Counter registers are 32 bit, so each 64-bit counter has a low and a high half
// Only six counters are addressable, matching the six alias slots
package perf_pkg;

  localparam int unsigned XLEN   = 32; // Register and bus data width
  localparam int unsigned ADDR_W = 10; // Word address width

  // One Wishbone classic request, 45 bits
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [XLEN-1:0]   dat;
  } wb_req_t;

  // Response, 33 bits
  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;
  } wb_rsp_t;

  // Cache event strobes, one cycle each except flushing
  typedef struct packed {
    logic hit;
    logic miss;
    logic flushing;   // Level while lines are walked
    logic flush_done; // Pulse after last line
    logic write;
  } cache_evt_t;

  // Event selector codes, anything above WRITE counts nothing
  typedef enum logic [4:0] {
    NONE       = 5'd0,
    MISS       = 5'd1,
    HIT        = 5'd2,
    FLUSHING   = 5'd3,
    FLUSH_DONE = 5'd4,
    CYCLE      = 5'd5,
    CONFLICT   = 5'd6,
    WRITE      = 5'd7
  } ev_sel_e;

  // Counter low halves
  localparam logic [11:0] CSR_MHPM_COUNTER_3  = 12'hB03;
  localparam logic [11:0] CSR_MHPM_COUNTER_4  = 12'hB04;
  localparam logic [11:0] CSR_MHPM_COUNTER_5  = 12'hB05;
  localparam logic [11:0] CSR_MHPM_COUNTER_6  = 12'hB06;
  localparam logic [11:0] CSR_MHPM_COUNTER_7  = 12'hB07;
  localparam logic [11:0] CSR_MHPM_COUNTER_8  = 12'hB08;
  // Counter high halves
  localparam logic [11:0] CSR_MHPM_COUNTER_3H = 12'hB83;
  localparam logic [11:0] CSR_MHPM_COUNTER_4H = 12'hB84;
  localparam logic [11:0] CSR_MHPM_COUNTER_5H = 12'hB85;
  localparam logic [11:0] CSR_MHPM_COUNTER_6H = 12'hB86;
  localparam logic [11:0] CSR_MHPM_COUNTER_7H = 12'hB87;
  localparam logic [11:0] CSR_MHPM_COUNTER_8H = 12'hB88;
  // Event selectors
  localparam logic [11:0] CSR_MHPM_EVENT_3    = 12'h323;
  localparam logic [11:0] CSR_MHPM_EVENT_4    = 12'h324;
  localparam logic [11:0] CSR_MHPM_EVENT_5    = 12'h325;
  localparam logic [11:0] CSR_MHPM_EVENT_6    = 12'h326;
  localparam logic [11:0] CSR_MHPM_EVENT_7    = 12'h327;
  localparam logic [11:0] CSR_MHPM_EVENT_8    = 12'h328;
  // Read-only aliases, alias n mirrors the low half of counter n+1
  localparam logic [11:0] CSR_EVT_ALIAS_0     = 12'hC10;
  localparam logic [11:0] CSR_EVT_ALIAS_1     = 12'hC11;
  localparam logic [11:0] CSR_EVT_ALIAS_2     = 12'hC12;
  localparam logic [11:0] CSR_EVT_ALIAS_3     = 12'hC13;
  localparam logic [11:0] CSR_EVT_ALIAS_4     = 12'hC14;
  localparam logic [11:0] CSR_EVT_ALIAS_5     = 12'hC15;

endpackage

// File: src/wb_arbiter.sv
// Round-robin arbiter for two Wishbone classic masters onto one slave
// Masters must hold a request stable until acked
// Grant is picked combinationally while idle so the slave sees stb without delay
// Port 0 wins the first contended decision after reset
`timescale 1ns/1ps

module wb_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  perf_pkg::wb_req_t m0_req_i,
  input  perf_pkg::wb_req_t m1_req_i,
  output perf_pkg::wb_rsp_t m0_rsp_o,
  output perf_pkg::wb_rsp_t m1_rsp_o,
  output perf_pkg::wb_req_t s_req_o,
  input  perf_pkg::wb_rsp_t s_rsp_i,
  output logic              conflict_o
);
  import perf_pkg::*;

  logic busy_q;  // Grant locked until ack
  logic gnt_q;   // Granted port while busy
  logic last_q;  // Port served last
  logic req0;
  logic req1;
  logic pick;    // Choice when idle
  logic sel;     // Port currently on the bus

  assign req0 = m0_req_i.cyc & m0_req_i.stb;
  assign req1 = m1_req_i.cyc & m1_req_i.stb;

  // Alternate on contention, else take whoever asks
  always_comb begin
    if (req0 && req1) begin
      pick = ~last_q;
    end else begin
      pick = req1; // Falls to port 0 when nobody asks
    end
  end

  assign sel = busy_q ? gnt_q : pick;

  assign s_req_o = sel ? m1_req_i : m0_req_i;

  // Only the granted port sees ack
  assign m0_rsp_o = '{ack: s_rsp_i.ack & ~sel, dat: s_rsp_i.dat};
  assign m1_rsp_o = '{ack: s_rsp_i.ack & sel, dat: s_rsp_i.dat};

  // One pulse per contended decision, busy drops the next cycle
  assign conflict_o = ~busy_q & req0 & req1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      gnt_q  <= 1'b0;
      last_q <= 1'b1; // Makes port 0 the first pick
    end else if (!busy_q) begin
      if (req0 || req1) begin
        busy_q <= 1'b1;
        gnt_q  <= pick;
      end
    end else if (s_rsp_i.ack) begin
      busy_q <= 1'b0; // Re-arbitrate next cycle
      last_q <= gnt_q;
    end
  end

endmodule

// File: src/dcache_lite.sv
// Direct-mapped write-through data cache with one word per line
// NumLines must be a power of two and at least 2
// Writes never allocate but a write hit updates the line as well as RAM
// Read hit acks one cycle after stb and a miss or write one cycle after the RAM ack
// Requests wait without ack while a flush walks every line
`timescale 1ns/1ps

module dcache_lite #(
  parameter int unsigned NumLines = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  perf_pkg::wb_req_t    req_i,
  output perf_pkg::wb_rsp_t    rsp_o,
  output perf_pkg::wb_req_t    mem_req_o,
  input  perf_pkg::wb_rsp_t    mem_rsp_i,
  input  logic                 flush_i,
  output perf_pkg::cache_evt_t evt_o
);
  import perf_pkg::*;

  localparam int unsigned IdxW = $clog2(NumLines);
  localparam int unsigned TagW = ADDR_W - IdxW;

  typedef enum logic [2:0] {
    S_IDLE,
    S_COMPARE,
    S_REFILL,
    S_WTHRU,
    S_FLUSH
  } state_e;

  state_e state_q;

  logic [TagW-1:0]     tag_q [NumLines];
  logic [XLEN-1:0]     data_q [NumLines];
  logic [NumLines-1:0] valid_q;

  logic [IdxW-1:0] idx;
  logic [TagW-1:0] tag;
  logic            req_valid;
  logic            hit;
  logic            mem_busy;
  logic            ack_q;        // Ack for refill and write-through
  logic [IdxW-1:0] flush_idx_q;
  logic            flush_pend_q; // Flush asked while busy
  logic            flush_done_q;

  assign idx       = req_i.adr[IdxW-1:0];
  assign tag       = req_i.adr[ADDR_W-1:IdxW];
  assign req_valid = req_i.cyc & req_i.stb;
  assign hit       = valid_q[idx] && (tag_q[idx] == tag);

  // RAM access starts in COMPARE so the refill costs only the RAM wait state
  assign mem_busy = (state_q == S_COMPARE && (req_i.we || !hit)) ||
                    state_q == S_REFILL || state_q == S_WTHRU;

  assign mem_req_o = '{
    cyc: mem_busy,
    stb: mem_busy,
    we:  req_i.we,
    adr: req_i.adr,
    dat: req_i.dat
  };

  // Read data straight from the array
  assign rsp_o = '{
    ack: ack_q | (state_q == S_COMPARE && !req_i.we && hit),
    dat: data_q[idx]
  };

  assign evt_o = '{
    hit:        state_q == S_COMPARE && !req_i.we && hit,
    miss:       state_q == S_COMPARE && !req_i.we && !hit,
    flushing:   state_q == S_FLUSH,
    flush_done: flush_done_q,
    write:      state_q == S_COMPARE && req_i.we
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= S_IDLE;
      valid_q      <= '0; // All lines invalid
      ack_q        <= 1'b0;
      flush_idx_q  <= '0;
      flush_pend_q <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      ack_q        <= 1'b0; // Pulses only
      flush_done_q <= 1'b0;
      if (flush_i) begin
        flush_pend_q <= 1'b1;
      end
      case (state_q)
        S_IDLE: begin
          if (flush_pend_q || flush_i) begin // Flush beats a new request
            state_q      <= S_FLUSH;
            flush_idx_q  <= '0;
            flush_pend_q <= 1'b0;
          end else if (req_valid && !ack_q) begin // Skip the request just acked
            state_q <= S_COMPARE;
          end
        end
        S_COMPARE: begin
          if (req_i.we) begin
            state_q <= S_WTHRU;
          end else if (hit) begin
            state_q <= S_IDLE;
          end else begin
            state_q <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (mem_rsp_i.ack) begin
            valid_q[idx] <= 1'b1;
            ack_q        <= 1'b1;
            state_q      <= S_IDLE;
          end
        end
        S_WTHRU: begin
          if (mem_rsp_i.ack) begin
            ack_q   <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        S_FLUSH: begin
          valid_q[flush_idx_q] <= 1'b0; // One line per cycle
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == IdxW'(NumLines - 1)) begin
            flush_done_q <= 1'b1;
            state_q      <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Line payload and tag
  always_ff @(posedge clk_i) begin
    if (state_q == S_COMPARE && req_i.we && hit) begin
      data_q[idx] <= req_i.dat; // Keep line in step with RAM
    end
    if (state_q == S_REFILL && mem_rsp_i.ack) begin
      data_q[idx] <= mem_rsp_i.dat;
      tag_q[idx]  <= tag;
    end
  end

endmodule

// File: src/backing_ram.sv
// Word-addressed RAM behind a Wishbone classic slave port
// One wait state, ack follows stb by a cycle and lasts one cycle
// Contents are undefined after reset
// RamWords must be a power of two no larger than 2**ADDR_W
`timescale 1ns/1ps

module backing_ram #(
  parameter int unsigned RamWords = 1024
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  perf_pkg::wb_req_t req_i,
  output perf_pkg::wb_rsp_t rsp_o
);
  import perf_pkg::*;

  localparam int unsigned AW = $clog2(RamWords);

  logic [XLEN-1:0] mem_q [RamWords];
  logic [AW-1:0]   word;
  logic            access;
  logic            ack_q;
  logic [XLEN-1:0] rdata_q;

  assign word   = req_i.adr[AW-1:0];          // Upper address bits ignored
  assign access = req_i.cyc & req_i.stb & ~ack_q; // No second access in the ack cycle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (req_i.we) begin
        mem_q[word] <= req_i.dat;
      end
      rdata_q <= mem_q[word]; // Old data on a write
    end
  end

  assign rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

// File: src/perf_counters.sv
// Six programmable 64-bit event counters with an SRAM-like register port
// Reads are combinational and writes land at the next edge
// A counter being written does not count in that cycle
// Counting stops while debug mode is high
// Unknown addresses read zero and ignore writes
`timescale 1ns/1ps

module perf_counters #(
  parameter int unsigned NumCounters = 6 // 1 to 6
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      debug_mode_i,
  input  perf_pkg::cache_evt_t      cache_evt_i,
  input  logic                      conflict_i,
  input  logic [11:0]               addr_i,
  input  logic                      we_i,
  input  logic [perf_pkg::XLEN-1:0] data_i,
  output logic [perf_pkg::XLEN-1:0] data_o
);
  import perf_pkg::*;

  logic [63:0] cnt_q [1:NumCounters];
  logic [63:0] cnt_d [1:NumCounters];
  ev_sel_e     sel_q [1:NumCounters];
  ev_sel_e     sel_d [1:NumCounters];

  logic [NumCounters:1] evt; // Selected event per counter

  // Event mux
  always_comb begin
    for (int i = 1; i <= NumCounters; i++) begin
      case (sel_q[i])
        MISS:       evt[i] = cache_evt_i.miss;
        HIT:        evt[i] = cache_evt_i.hit;
        FLUSHING:   evt[i] = cache_evt_i.flushing;
        FLUSH_DONE: evt[i] = cache_evt_i.flush_done;
        CYCLE:      evt[i] = 1'b1; // Every clock
        CONFLICT:   evt[i] = conflict_i;
        WRITE:      evt[i] = cache_evt_i.write;
        default:    evt[i] = 1'b0; // NONE and spare codes
      endcase
    end
  end

  // Count first and let a register write override
  always_comb begin
    cnt_d = cnt_q;
    sel_d = sel_q;
    for (int i = 1; i <= NumCounters; i++) begin
      if (!debug_mode_i && evt[i]) begin
        cnt_d[i] = cnt_q[i] + 64'd1;
      end
      if (we_i) begin
        if (addr_i == CSR_MHPM_COUNTER_3 + 12'(i - 1)) begin
          cnt_d[i] = {cnt_q[i][63:32], data_i}; // Low half with high half kept
        end
        if (addr_i == CSR_MHPM_COUNTER_3H + 12'(i - 1)) begin
          cnt_d[i] = {data_i, cnt_q[i][31:0]};
        end
        if (addr_i == CSR_MHPM_EVENT_3 + 12'(i - 1)) begin
          sel_d[i] = ev_sel_e'(data_i[4:0]); // Upper bits dropped
        end
      end
    end
  end

  // Read decode
  always_comb begin
    data_o = '0;
    for (int i = 1; i <= NumCounters; i++) begin
      if (addr_i == CSR_MHPM_COUNTER_3 + 12'(i - 1)) begin
        data_o = cnt_q[i][31:0];
      end
      if (addr_i == CSR_MHPM_COUNTER_3H + 12'(i - 1)) begin
        data_o = cnt_q[i][63:32];
      end
      if (addr_i == CSR_MHPM_EVENT_3 + 12'(i - 1)) begin
        data_o = XLEN'(sel_q[i]);
      end
      if (addr_i == CSR_EVT_ALIAS_0 + 12'(i - 1)) begin
        data_o = cnt_q[i][31:0]; // Alias n is counter n+1
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '{default: '0};
      sel_q <= '{default: NONE};
    end else begin
      cnt_q <= cnt_d;
      sel_q <= sel_d;
    end
  end

endmodule

// File: src/cache_perf_top.sv
// Data cache complex with performance counters
// Two masters share the cache through a round-robin arbiter
// The cache fills from a one-wait-state RAM
// Counter registers reached through the csr port, one access per cycle
`timescale 1ns/1ps

module cache_perf_top #(
  parameter int unsigned NumLines    = 16,
  parameter int unsigned RamWords    = 1024,
  parameter int unsigned NumCounters = 6
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  perf_pkg::wb_req_t         m0_req_i,
  input  perf_pkg::wb_req_t         m1_req_i,
  output perf_pkg::wb_rsp_t         m0_rsp_o,
  output perf_pkg::wb_rsp_t         m1_rsp_o,
  input  logic                      flush_i,
  input  logic                      debug_mode_i,
  input  logic [11:0]               csr_addr_i,
  input  logic                      csr_we_i,
  input  logic [perf_pkg::XLEN-1:0] csr_wdata_i,
  output logic [perf_pkg::XLEN-1:0] csr_rdata_o
);
  import perf_pkg::*;

  wb_req_t    arb_req;   // Arbiter to cache
  wb_rsp_t    arb_rsp;
  wb_req_t    mem_req;   // Cache to RAM
  wb_rsp_t    mem_rsp;
  cache_evt_t cache_evt;
  logic       conflict;

  wb_arbiter i_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .m0_req_i   (m0_req_i),
    .m1_req_i   (m1_req_i),
    .m0_rsp_o   (m0_rsp_o),
    .m1_rsp_o   (m1_rsp_o),
    .s_req_o    (arb_req),
    .s_rsp_i    (arb_rsp),
    .conflict_o (conflict)
  );

  dcache_lite #(.NumLines(NumLines)) i_dcache (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (arb_req),
    .rsp_o     (arb_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .flush_i   (flush_i),
    .evt_o     (cache_evt)
  );

  backing_ram #(.RamWords(RamWords)) i_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .rsp_o  (mem_rsp)
  );

  perf_counters #(.NumCounters(NumCounters)) i_perf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .debug_mode_i (debug_mode_i),
    .cache_evt_i  (cache_evt),
    .conflict_i   (conflict),
    .addr_i       (csr_addr_i),
    .we_i         (csr_we_i),
    .data_i       (csr_wdata_i),
    .data_o       (csr_rdata_o)
  );

endmodule

// File: verification/tb_tasks.svh
// Driver, check and directed test tasks included in the testbench module body
// A bus transfer holds its request until ack and then idles the port one cycle
// Counter numbers run 1 to 6 with counter n at mhpmcounter n+2

  // LCG with the usual Numerical Recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    rst_n      = 1'b0;
    m0_req     = '0;
    m1_req     = '0;
    flush      = 1'b0;
    debug_mode = 1'b0;
    csr_addr   = '0;
    csr_we     = 1'b0;
    csr_wdata  = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    flush_model(); // All lines invalid
    last_port = 1; // So port 0 wins first
  endtask

  // One Wishbone classic transfer on port 0 or 1
  task automatic bus_access(input int port, input logic we, input logic [9:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat,
                            output int ack_cycle);
    wb_req_t req;
    wb_rsp_t rsp;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    @(negedge clk);
    if (port == 0) begin
      m0_req = req;
    end else begin
      m1_req = req;
    end
    do begin
      @(negedge clk);
      rsp = (port == 0) ? m0_rsp : m1_rsp;
    end while (rsp.ack !== 1'b1);
    rdat      = rsp.dat;
    ack_cycle = cycle_cnt;
    @(negedge clk); // Ack was taken at the edge just passed
    if (port == 0) begin
      m0_req = '0;
    end else begin
      m1_req = '0;
    end
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    @(negedge clk);
    csr_addr  = addr;
    csr_wdata = data;
    csr_we    = 1'b1;
    @(negedge clk); // Write lands on the edge in between
    csr_we = 1'b0;
  endtask

  // Combinational read sampled well before the next rising edge
  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    @(negedge clk);
    csr_addr = addr;
    #1;
    data = csr_rdata;
  endtask

  task automatic write_counter(input int n, input logic [63:0] value);
    csr_write(CSR_MHPM_COUNTER_3 + 12'(n - 1), value[31:0]);
    csr_write(CSR_MHPM_COUNTER_3H + 12'(n - 1), value[63:32]);
  endtask

  task automatic select_event(input int n, input logic [4:0] code);
    csr_write(CSR_MHPM_EVENT_3 + 12'(n - 1), {27'd0, code});
  endtask

  task automatic expect_counter(input int n, input logic [63:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    csr_read(CSR_MHPM_COUNTER_3 + 12'(n - 1), lo);
    csr_read(CSR_MHPM_COUNTER_3H + 12'(n - 1), hi);
    check_equal($sformatf("mhpmcounter%0d", n + 2), {hi, lo}, exp);
  endtask

  // Reset values followed by random writes on both ports and read-back
  task automatic data_integrity();
    logic [31:0] value;
    for (int n = 1; n <= 6; n++) begin
      expect_counter(n, 64'd0);
      csr_read(CSR_MHPM_EVENT_3 + 12'(n - 1), value);
      check_equal($sformatf("mhpmevent%0d", n + 2), value, 0);
      csr_read(CSR_EVT_ALIAS_0 + 12'(n - 1), value);
      check_equal($sformatf("alias%0d", n - 1), value, 0);
    end
    for (int k = 0; k < N_WORDS; k++) begin
      value = next_rand();
      cached_write(k % 2, value[21:12], next_rand());
    end
    for (int k = 0; k < N_WORDS; k++) begin
      cached_read((k + 1) % 2, written_q[k]); // Other port than the writer
    end
  endtask

  task automatic hit_miss_counting();
    logic [31:0] value;
    select_event(1, MISS);
    select_event(2, HIT);
    hit_exp  = 0;
    miss_exp = 0;
    for (int k = 0; k < N_HM; k++) begin
      cached_read(0, written_q[k]);
      cached_read(1, written_q[k]); // Same word again
      cached_read(k % 2, written_q[(k * 7) % N_WORDS]);
    end
    expect_counter(1, miss_exp);
    expect_counter(2, hit_exp);
    csr_read(CSR_EVT_ALIAS_0, value);
    check_equal("alias0", value, miss_exp);
    csr_read(CSR_EVT_ALIAS_1, value);
    check_equal("alias1", value, hit_exp);
  endtask

  task automatic flush_sequence();
    logic [31:0] r;
    logic [31:0] done;
    logic [9:0]  adr [N_FL];
    int          polls;
    for (int k = 0; k < N_FL; k++) begin
      r      = next_rand();
      adr[k] = (r[21:12] & ~10'(NUM_LINES - 1)) | 10'(k); // Line k with a random tag
      cached_write(k % 2, adr[k], next_rand());
    end
    select_event(3, FLUSHING);
    select_event(4, FLUSH_DONE);
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    flush_model();
    polls = 0;
    do begin
      csr_read(CSR_MHPM_COUNTER_6, done); // Counter 4 counts flush_done
      polls++;
    end while (done == 0 && polls < 4 * NUM_LINES);
    if (done == 0) begin
      n_errors++;
      $display("flush did not report done within %0d register polls", polls);
    end
    expect_counter(3, NUM_LINES);
    expect_counter(4, 1);
    write_counter(1, 0);
    write_counter(2, 0);
    for (int k = 0; k < N_FL; k++) begin
      cached_read(k % 2, adr[k]);
    end
    expect_counter(1, N_FL); // Every read misses after the flush
    expect_counter(2, 0);
  endtask

  // Both ports request in the same cycle with writes first and reads after
  task automatic arbitration();
    logic [31:0] r;
    logic [9:0]  adr [2][N_ARB];
    logic [31:0] rdat [2];
    int          ackc [2];
    int          first;
    apply_reset();
    select_event(3, CONFLICT);
    for (int k = 0; k < N_ARB; k++) begin
      for (int p = 0; p < 2; p++) begin
        r            = next_rand();
        adr[p][k]    = {r[20:12], p[0]}; // Even words for m0 and odd for m1
        shadow[adr[p][k]] = next_rand();
      end
    end
    for (int ph = 0; ph < 2; ph++) begin
      for (int k = 0; k < N_ARB; k++) begin
        if (ph == 1 && k % 2 == 1) begin
          cached_read(0, written_q[0]); // Lone m0 read makes m1 the next pick
          last_port = 0;
        end
        first = (last_port == 1) ? 0 : 1;
        fork
          bus_access(0, ph == 0, adr[0][k], shadow[adr[0][k]], rdat[0], ackc[0]);
          bus_access(1, ph == 0, adr[1][k], shadow[adr[1][k]], rdat[1], ackc[1]);
        join
        check_equal("first acked port", (ackc[0] < ackc[1]) ? 0 : 1, first);
        last_port = 1 - first;
        if (ph == 1) begin
          check_equal("m0_rsp.dat", rdat[0], shadow[adr[0][k]]);
          check_equal("m1_rsp.dat", rdat[1], shadow[adr[1][k]]);
        end
      end
    end
    expect_counter(3, 2 * N_ARB); // One contended decision per round
  endtask

  task automatic register_access();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] al;
    int          low_cycles;
    @(negedge clk);
    debug_mode = 1'b1; // Counting frozen
    for (int n = 1; n <= 6; n++) begin
      lo = next_rand();
      hi = next_rand();
      write_counter(n, {hi, lo});
      expect_counter(n, {hi, lo});
      csr_read(CSR_EVT_ALIAS_0 + 12'(n - 1), al);
      check_equal($sformatf("alias%0d", n - 1), al, lo);
      csr_write(CSR_MHPM_EVENT_3 + 12'(n - 1), hi);
      csr_read(CSR_MHPM_EVENT_3 + 12'(n - 1), lo);
      check_equal($sformatf("mhpmevent%0d", n + 2), lo, hi[4:0]); // 5-bit field
    end
    csr_write(12'h7FF, 32'hFFFF_FFFF); // Unmapped
    csr_read(12'h7FF, lo);
    check_equal("csr_rdata unmapped", lo, 0);
    select_event(5, CYCLE);
    write_counter(5, 64'h1_FFFF_FFF0); // Low half carries during the run
    low_cycles = 0;
    for (int seg = 0; seg < 3; seg++) begin
      debug_mode = 1'b0;
      repeat (5 + 3 * seg) @(negedge clk);
      low_cycles += 5 + 3 * seg;
      debug_mode = 1'b1;
      repeat (4) @(negedge clk);
    end
    expect_counter(5, 64'h1_FFFF_FFF0 + low_cycles);
  endtask

// File: verification/tb_cache_perf.sv
// Testbench for the cache and counter complex
// Inputs change on the falling clock edge only
// Shadow memory and a tag model predict read data, hits and misses
// NUM_LINES must match the cache size passed to the DUT
`timescale 1ns/1ps

module tb_cache_perf;
  import perf_pkg::*;

  localparam int unsigned NUM_LINES = 16;
  localparam int unsigned RAM_WORDS = 1024;
  localparam int N_WORDS = 24; // Random words in the integrity test
  localparam int N_HM    = 12; // Read triples for hit and miss counting
  localparam int N_FL    = 8;  // Lines read back after a flush
  localparam int N_ARB   = 6;  // Contended rounds per phase
  localparam int BUS_OPS = 2 * N_WORDS + 3 * N_HM + 2 * N_FL + 4 * N_ARB;
  localparam int CSR_OPS = 200; // Upper bound on register accesses
  // Bus op ends within 7 cycles, register access within 2, doubled for margin
  localparam int TIMEOUT_CYCLES = 2 * (7 * BUS_OPS + 2 * CSR_OPS + 4 * NUM_LINES + 100);

  logic        clk;
  logic        rst_n;
  wb_req_t     m0_req;
  wb_req_t     m1_req;
  wb_rsp_t     m0_rsp;
  wb_rsp_t     m1_rsp;
  logic        flush;
  logic        debug_mode;
  logic [11:0] csr_addr;
  logic        csr_we;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;

  int          cycle_cnt;
  int          n_checks;
  int          n_errors;
  logic [31:0] lcg_state;

  // Reference state
  logic [31:0] shadow [RAM_WORDS];
  logic [9:0]  written_q [$];     // Addresses safe to read
  logic        valid_m [NUM_LINES];
  logic [9:0]  tag_m [NUM_LINES];
  int          hit_exp;
  int          miss_exp;
  int          last_port;         // Port served last by the arbiter

  cache_perf_top #(
    .NumLines    (NUM_LINES),
    .RamWords    (RAM_WORDS),
    .NumCounters (6)
  ) uut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .m0_req_i     (m0_req),
    .m1_req_i     (m1_req),
    .m0_rsp_o     (m0_rsp),
    .m1_rsp_o     (m1_rsp),
    .flush_i      (flush),
    .debug_mode_i (debug_mode),
    .csr_addr_i   (csr_addr),
    .csr_we_i     (csr_we),
    .csr_wdata_i  (csr_wdata),
    .csr_rdata_o  (csr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Read with hit or miss prediction, miss allocates the line
  task automatic cached_read(input int port, input logic [9:0] adr);
    int          idx;
    logic [9:0]  tg;
    logic [31:0] rdat;
    int          ackc;
    idx = adr % NUM_LINES;
    tg  = adr / NUM_LINES;
    if (valid_m[idx] && tag_m[idx] == tg) begin
      hit_exp++;
    end else begin
      miss_exp++;
      valid_m[idx] = 1'b1;
      tag_m[idx]   = tg;
    end
    bus_access(port, 1'b0, adr, 32'h0, rdat, ackc);
    check_equal($sformatf("m%0d_rsp.dat", port), rdat, shadow[adr]);
  endtask

  // Write-through, tag model untouched
  task automatic cached_write(input int port, input logic [9:0] adr, input logic [31:0] dat);
    logic [31:0] rdat;
    int          ackc;
    shadow[adr] = dat;
    written_q.push_back(adr);
    bus_access(port, 1'b1, adr, dat, rdat, ackc);
  endtask

  task automatic flush_model();
    for (int i = 0; i < NUM_LINES; i++) begin
      valid_m[i] = 1'b0;
    end
  endtask

  `include "tb_tasks.svh"

  initial begin
    lcg_state = 32'h9a426e4d;
    apply_reset();
    data_integrity();
    hit_miss_counting();
    flush_sequence();
    arbitration();
    register_access();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verification
src/perf_pkg.sv
src/wb_arbiter.sv
src/dcache_lite.sv
src/backing_ram.sv
src/perf_counters.sv
src/cache_perf_top.sv
verification/tb_cache_perf.sv
